// File: src/fabric_cfg_pkg.sv
//////////////////////////////
// memory fabric configuration
// bus geometry and tracker sizing
//////////////////////////////

`default_nettype none

package fabric_cfg_pkg;

    // data widths
    localparam int unsigned BUS_W      = 64;  // bus and vector data word
    localparam int unsigned WORD_W     = 32;  // scalar and instruction word
    localparam int unsigned ADDR_W     = 32;

    // lane geometry
    localparam int unsigned LANES      = BUS_W / WORD_W;
    localparam int unsigned LANE_SEL_W = 1;
    localparam int unsigned LANE_LSB   = $clog2(WORD_W / 8);  // byte offset bits within a lane
    localparam int unsigned BE_W       = BUS_W / 8;

    // transaction tracker
    localparam int unsigned TXN_DEPTH  = 8;
    localparam int unsigned TXN_CNT_W  = 4;  // holds 0 .. TXN_DEPTH
    localparam int unsigned TXN_PTR_W  = $clog2(TXN_DEPTH);

endpackage

`default_nettype wire

// File: src/fabric_types_pkg.sv
//////////////////////////////
// memory fabric types
// requests, responses, tracker entries and the bus word
//////////////////////////////

`default_nettype none

package fabric_types_pkg;

    import fabric_cfg_pkg::*;

    // owner of a bus transaction
    typedef enum logic [1:0] {
        SRC_FETCH  = 2'd0,
        SRC_SCALAR = 2'd1,
        SRC_VECTOR = 2'd2
    } src_e;

    // one bus word, seen whole by the vector side and per lane by the 32-bit side
    typedef union packed {
        logic [BUS_W-1:0]              full;
        logic [LANES-1:0][WORD_W-1:0]  lane;
    } bus_word_u;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic                valid;
        logic                we;
        logic [ADDR_W-1:0]   addr;
        logic [WORD_W/8-1:0] be;
        logic [WORD_W-1:0]   wdata;
    } scalar_req_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        logic [BUS_W-1:0]  wdata;
    } vector_req_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        bus_word_u         wdata;
    } bus_req_t;

    typedef struct packed {
        src_e                  src;
        logic                  we;
        logic [LANE_SEL_W-1:0] lane;  // lane of the 32-bit word
    } txn_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [WORD_W-1:0] data;
    } word_rsp_t;

    typedef struct packed {
        logic             valid;
        logic             err;
        logic [BUS_W-1:0] data;
    } vector_rsp_t;

endpackage

`default_nettype wire

// File: src/mem_req_arbiter.sv
//////////////////////////////
// memory request arbiter
// picks the bus owner and steers scalar data onto its lane
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_req_arbiter (
    input  fabric_types_pkg::fetch_req_t  fetch_req_i,
    input  fabric_types_pkg::scalar_req_t scalar_req_i,
    input  fabric_types_pkg::vector_req_t vector_req_i,
    input  logic                          pending_load_i,
    input  logic                          pending_store_i,
    input  logic                          txn_full_i,
    output logic                          fetch_gnt_o,
    output logic                          scalar_gnt_o,
    output logic                          vector_gnt_o,
    output fabric_types_pkg::bus_req_t    bus_req_o,
    output fabric_types_pkg::txn_t        txn_o
);

    import fabric_cfg_pkg::*;
    import fabric_types_pkg::*;

    logic                  scalar_hold;
    logic                  vector_win;
    logic                  scalar_win;
    logic                  fetch_win;
    logic [LANE_SEL_W-1:0] fetch_lane;
    logic [LANE_SEL_W-1:0] scalar_lane;
    logic [LANE_SEL_W-1:0] vector_lane;

    //////////////////////////////
    // priority and hold

    // scalar access must not overtake vector memory traffic
    assign scalar_hold = pending_store_i | (pending_load_i & scalar_req_i.we);

    assign vector_win = vector_req_i.valid;
    assign scalar_win = scalar_req_i.valid & ~scalar_hold & ~vector_win;
    assign fetch_win  = fetch_req_i.valid & ~vector_win & ~scalar_win;

    // no new transaction while the tracker has no room
    assign vector_gnt_o = vector_win & ~txn_full_i;
    assign scalar_gnt_o = scalar_win & ~txn_full_i;
    assign fetch_gnt_o  = fetch_win  & ~txn_full_i;

    assign fetch_lane  = fetch_req_i.addr[LANE_LSB +: LANE_SEL_W];
    assign scalar_lane = scalar_req_i.addr[LANE_LSB +: LANE_SEL_W];
    assign vector_lane = vector_req_i.addr[LANE_LSB +: LANE_SEL_W];

    //////////////////////////////
    // bus request forming

    always_comb begin
        bus_req_o     = '0;
        bus_req_o.req = fetch_gnt_o | scalar_gnt_o | vector_gnt_o;
        txn_o         = '0;
        if (vector_win) begin
            bus_req_o.we         = vector_req_i.we;
            bus_req_o.addr       = vector_req_i.addr;
            bus_req_o.be         = vector_req_i.be;  // passed unchanged
            bus_req_o.wdata.full = vector_req_i.wdata;
            txn_o.src            = SRC_VECTOR;
            txn_o.we             = vector_req_i.we;
            txn_o.lane           = vector_lane;
        end else if (scalar_win) begin
            bus_req_o.we   = scalar_req_i.we;
            bus_req_o.addr = scalar_req_i.addr;
            for (int i = 0; i < LANES; i++) begin
                bus_req_o.wdata.lane[i] = scalar_req_i.wdata;  // copy into every lane
                if (scalar_lane == LANE_SEL_W'(i)) begin
                    bus_req_o.be[i*(WORD_W/8) +: WORD_W/8] = scalar_req_i.be;
                end
            end
            txn_o.src  = SRC_SCALAR;
            txn_o.we   = scalar_req_i.we;
            txn_o.lane = scalar_lane;
        end else begin
            bus_req_o.addr = fetch_req_i.addr;
            bus_req_o.be   = '1;  // fetch reads the whole word
            txn_o.src      = SRC_FETCH;
            txn_o.lane     = fetch_lane;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_txn_tracker.sv
//////////////////////////////
// transaction tracker
// in-order queue of granted bus transactions
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_txn_tracker (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    input  fabric_types_pkg::txn_t txn_i,
    input  logic                   pop_i,
    output fabric_types_pkg::txn_t head_o,
    output logic                   empty_o,
    output logic                   full_o
);

    import fabric_cfg_pkg::*;
    import fabric_types_pkg::*;

    txn_t                 fifo_q [TXN_DEPTH];
    logic [TXN_PTR_W-1:0] wr_ptr_q;
    logic [TXN_PTR_W-1:0] rd_ptr_q;
    logic [TXN_CNT_W-1:0] cnt_q;
    logic                 do_push;
    logic                 do_pop;

    assign full_o  = (cnt_q == TXN_CNT_W'(TXN_DEPTH));
    assign empty_o = (cnt_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign head_o  = fifo_q[rd_ptr_q];  // oldest outstanding transaction

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            fifo_q[wr_ptr_q] <= txn_i;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + TXN_CNT_W'(1);
                2'b01:   cnt_q <= cnt_q - TXN_CNT_W'(1);
                default: cnt_q <= cnt_q;  // idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/mem_resp_router.sv
//////////////////////////////
// memory response router
// hands each bus response to the owner of the oldest transaction
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_resp_router (
    input  logic                           mem_rvalid_i,
    input  logic                           mem_err_i,
    input  fabric_types_pkg::bus_word_u    mem_rdata_i,
    input  fabric_types_pkg::txn_t         head_i,
    input  logic                           empty_i,
    output logic                           pop_o,
    output fabric_types_pkg::word_rsp_t    fetch_rsp_o,
    output fabric_types_pkg::word_rsp_t    scalar_rsp_o,
    output fabric_types_pkg::vector_rsp_t  vector_rsp_o
);

    import fabric_types_pkg::*;

    logic accept;
    logic to_fetch;
    logic to_scalar;
    logic to_vector;

    // a response with nothing outstanding is dropped
    assign accept = mem_rvalid_i & ~empty_i;
    assign pop_o  = accept;

    assign to_fetch  = accept & (head_i.src == SRC_FETCH);
    assign to_scalar = accept & (head_i.src == SRC_SCALAR);
    assign to_vector = accept & (head_i.src == SRC_VECTOR);

    assign fetch_rsp_o.valid  = to_fetch;
    assign fetch_rsp_o.err    = to_fetch & mem_err_i;
    assign fetch_rsp_o.data   = mem_rdata_i.lane[head_i.lane];  // lane of the stored address

    assign scalar_rsp_o.valid = to_scalar;
    assign scalar_rsp_o.err   = to_scalar & mem_err_i;
    assign scalar_rsp_o.data  = mem_rdata_i.lane[head_i.lane];

    assign vector_rsp_o.valid = to_vector;
    assign vector_rsp_o.err   = to_vector & mem_err_i;
    assign vector_rsp_o.data  = mem_rdata_i.full;

endmodule

`default_nettype wire

// File: src/vproc_mem_fabric.sv
//////////////////////////////
// vector processor memory fabric
// shares one bus among fetch, scalar and vector ports
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vproc_mem_fabric (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  fabric_types_pkg::fetch_req_t   fetch_req_i,
    input  fabric_types_pkg::scalar_req_t  scalar_req_i,
    input  fabric_types_pkg::vector_req_t  vector_req_i,
    input  logic                           pending_load_i,
    input  logic                           pending_store_i,
    output logic                           fetch_gnt_o,
    output logic                           scalar_gnt_o,
    output logic                           vector_gnt_o,
    output fabric_types_pkg::bus_req_t     mem_req_o,
    input  logic                           mem_rvalid_i,
    input  logic                           mem_err_i,
    input  fabric_types_pkg::bus_word_u    mem_rdata_i,
    output fabric_types_pkg::word_rsp_t    fetch_rsp_o,
    output fabric_types_pkg::word_rsp_t    scalar_rsp_o,
    output fabric_types_pkg::vector_rsp_t  vector_rsp_o
);

    import fabric_types_pkg::*;

    txn_t txn;
    txn_t txn_head;
    logic txn_full;
    logic txn_empty;
    logic txn_pop;

    mem_req_arbiter mem_req_arbiter_i (
        .fetch_req_i     ( fetch_req_i     ),
        .scalar_req_i    ( scalar_req_i    ),
        .vector_req_i    ( vector_req_i    ),
        .pending_load_i  ( pending_load_i  ),
        .pending_store_i ( pending_store_i ),
        .txn_full_i      ( txn_full        ),
        .fetch_gnt_o     ( fetch_gnt_o     ),
        .scalar_gnt_o    ( scalar_gnt_o    ),
        .vector_gnt_o    ( vector_gnt_o    ),
        .bus_req_o       ( mem_req_o       ),
        .txn_o           ( txn             )
    );

    // bus req is high exactly when one of the grants is
    mem_txn_tracker mem_txn_tracker_i (
        .clk_i   ( clk_i         ),
        .rst_ni  ( rst_ni        ),
        .push_i  ( mem_req_o.req ),
        .txn_i   ( txn           ),
        .pop_i   ( txn_pop       ),
        .head_o  ( txn_head      ),
        .empty_o ( txn_empty     ),
        .full_o  ( txn_full      )
    );

    mem_resp_router mem_resp_router_i (
        .mem_rvalid_i ( mem_rvalid_i ),
        .mem_err_i    ( mem_err_i    ),
        .mem_rdata_i  ( mem_rdata_i  ),
        .head_i       ( txn_head     ),
        .empty_i      ( txn_empty    ),
        .pop_o        ( txn_pop      ),
        .fetch_rsp_o  ( fetch_rsp_o  ),
        .scalar_rsp_o ( scalar_rsp_o ),
        .vector_rsp_o ( vector_rsp_o )
    );

endmodule

`default_nettype wire

// File: dv/mem_fabric_chk.sv
//////////////////////////////
// memory fabric checker
// grant exclusivity and response routing
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_fabric_chk (
    input logic                          clk_i,
    input logic                          rst_ni,
    input logic                          fetch_gnt_i,
    input logic                          scalar_gnt_i,
    input logic                          vector_gnt_i,
    input fabric_types_pkg::word_rsp_t   fetch_rsp_i,
    input fabric_types_pkg::word_rsp_t   scalar_rsp_i,
    input fabric_types_pkg::vector_rsp_t vector_rsp_i
);

    import fabric_cfg_pkg::*;

    logic                 any_gnt;
    logic                 any_rsp;
    logic [TXN_CNT_W-1:0] outstanding_q;  // granted and not yet answered

    assign any_gnt = fetch_gnt_i | scalar_gnt_i | vector_gnt_i;
    assign any_rsp = fetch_rsp_i.valid | scalar_rsp_i.valid | vector_rsp_i.valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= '0;
        end else begin
            outstanding_q <= outstanding_q + TXN_CNT_W'(any_gnt) - TXN_CNT_W'(any_rsp);
        end
    end

    one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({fetch_gnt_i, scalar_gnt_i, vector_gnt_i}))
        else $error("more than one requester granted");

    one_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({fetch_rsp_i.valid, scalar_rsp_i.valid, vector_rsp_i.valid}))
        else $error("response routed to more than one owner");

    // every response answers an earlier grant
    rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        any_rsp |-> outstanding_q != '0)
        else $error("response with no transaction outstanding");

    no_gnt_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        outstanding_q == TXN_CNT_W'(TXN_DEPTH) |-> !any_gnt)
        else $error("grant while the tracker is full");

endmodule

`default_nettype wire

// File: dv/tb_vproc_mem_fabric.sv
//////////////////////////////
// memory fabric testbench
// random three-source traffic against memory and reference models
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_vproc_mem_fabric;

    import fabric_cfg_pkg::*;
    import fabric_types_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_LAT    = 4;
    localparam int TOTAL_TXN  = 600;

    typedef struct packed {
        src_e             src;
        logic             we;
        logic             err;
        logic             lane;
        logic [BUS_W-1:0] data;  // read data at the requester's own address
    } exp_t;

    typedef struct packed {
        int               due;  // cycle in which the memory answers
        logic             err;
        logic [BUS_W-1:0] data;
    } mem_rsp_t;

    logic        clk_i;
    logic        rst_ni;
    fetch_req_t  fetch_req;
    scalar_req_t scalar_req;
    vector_req_t vector_req;
    logic        pending_load;
    logic        pending_store;
    logic        fetch_gnt;
    logic        scalar_gnt;
    logic        vector_gnt;
    bus_req_t    mem_req;
    logic        mem_rvalid;
    logic        mem_err;
    bus_word_u   mem_rdata;
    word_rsp_t   fetch_rsp;
    word_rsp_t   scalar_rsp;
    vector_rsp_t vector_rsp;

    logic [31:0]      rng_state = 32'h0dad_146d;
    logic [BUS_W-1:0] mem [logic [ADDR_W-4:0]];  // sparse with one entry per bus word
    mem_rsp_t         resp_q [$];
    exp_t             exp_q [$];
    logic [2:0]       gnt_seen;  // fetch, scalar, vector
    int               cycle;
    int               last_due;
    int               grants;
    int               total_grants;
    int               full_cycles;
    int               test_errors;
    int               errors;

    vproc_mem_fabric vproc_mem_fabric_i (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .fetch_req_i     ( fetch_req     ),
        .scalar_req_i    ( scalar_req    ),
        .vector_req_i    ( vector_req    ),
        .pending_load_i  ( pending_load  ),
        .pending_store_i ( pending_store ),
        .fetch_gnt_o     ( fetch_gnt     ),
        .scalar_gnt_o    ( scalar_gnt    ),
        .vector_gnt_o    ( vector_gnt    ),
        .mem_req_o       ( mem_req       ),
        .mem_rvalid_i    ( mem_rvalid    ),
        .mem_err_i       ( mem_err       ),
        .mem_rdata_i     ( mem_rdata     ),
        .fetch_rsp_o     ( fetch_rsp     ),
        .scalar_rsp_o    ( scalar_rsp    ),
        .vector_rsp_o    ( vector_rsp    )
    );

    bind vproc_mem_fabric mem_fabric_chk mem_fabric_chk_i (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .fetch_gnt_i  ( fetch_gnt_o  ),
        .scalar_gnt_i ( scalar_gnt_o ),
        .vector_gnt_i ( vector_gnt_o ),
        .fetch_rsp_i  ( fetch_rsp_o  ),
        .scalar_rsp_i ( scalar_rsp_o ),
        .vector_rsp_i ( vector_rsp_o )
    );

    //////////////////////////////
    // random numbers and memory

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic bit chance(input int rate);  // rate out of 8
        return int'(next_rand() % 8) < rate;
    endfunction

    // one access in 16 falls into the error range at the top
    function automatic logic [ADDR_W-1:0] rand_addr(input logic [31:0] r);
        return ((r[3:0] == 4'h0) ? 32'hf000_0000 : 32'h1000_0000) | {24'h0, r[9:4], 2'b00};
    endfunction

    function automatic logic [BUS_W-1:0] mem_read(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] a;
        a = {addr[ADDR_W-1:3], 3'b000};
        if (mem.exists(addr[ADDR_W-1:3])) begin
            return mem[addr[ADDR_W-1:3]];
        end
        return {~a, a ^ 32'h5a5a_c3c3};  // untouched words
    endfunction

    //////////////////////////////
    // compare tasks

    task automatic check_grants(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("** Error %0t ns: grants fetch/scalar/vector got %b expected %b",
                     $time, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bus_req(input bus_req_t got, input bus_req_t exp);
        if (got.req !== exp.req || (exp.req && (got.we !== exp.we || got.addr !== exp.addr
                || got.be !== exp.be || (exp.we && got.wdata !== exp.wdata)))) begin
            // req we addr be wdata
            $display("** Error %0t ns: bus got %b%b %h %h %h, expected %b%b %h %h %h",
                     $time, got.req, got.we, got.addr, got.be, got.wdata,
                     exp.req, exp.we, exp.addr, exp.be, exp.wdata);
            test_errors++;
        end
    endtask

    task automatic check_word_rsp(input string what, input word_rsp_t got, input word_rsp_t exp,
                                  input bit cmp_data);
        if (got.valid !== exp.valid || got.err !== exp.err
                || (cmp_data && got.data !== exp.data)) begin
            $display("** Error %0t ns: %s response got v%b e%b %h, expected v%b e%b %h",
                     $time, what, got.valid, got.err, got.data, exp.valid, exp.err, exp.data);
            test_errors++;
        end
    endtask

    task automatic check_vector_rsp(input vector_rsp_t got, input vector_rsp_t exp,
                                    input bit cmp_data);
        if (got.valid !== exp.valid || got.err !== exp.err
                || (cmp_data && got.data !== exp.data)) begin
            $display("** Error %0t ns: vector response got v%b e%b %h, expected v%b e%b %h",
                     $time, got.valid, got.err, got.data, exp.valid, exp.err, exp.data);
            test_errors++;
        end
    endtask

    //////////////////////////////
    // stimulus and models

    task automatic drive_inputs(input int req_rate, input int pend_rate, input bit issue);
        logic [31:0] r;
        // a requester moves on only after its grant
        if (!fetch_req.valid || gnt_seen[2]) begin
            fetch_req.valid = issue && chance(req_rate);
            fetch_req.addr  = rand_addr(next_rand());
        end
        if (!scalar_req.valid || gnt_seen[1]) begin
            r                = next_rand();
            scalar_req.valid = issue && chance(req_rate);
            scalar_req.we    = r[31];
            scalar_req.addr  = rand_addr(r);
            scalar_req.be    = r[23:20];
            scalar_req.wdata = next_rand();
        end
        if (!vector_req.valid || gnt_seen[0]) begin
            r                = next_rand();
            vector_req.valid = issue && chance(req_rate);
            vector_req.we    = r[30];
            vector_req.addr  = rand_addr(r) & ~32'h7;
            vector_req.be    = r[19:12];
            vector_req.wdata = {next_rand(), next_rand()};
        end
        pending_load  = chance(pend_rate);
        pending_store = chance(pend_rate);
        if (resp_q.size() > 0 && resp_q[0].due <= cycle) begin
            mem_rvalid     = 1'b1;
            mem_err        = resp_q[0].err;
            mem_rdata.full = resp_q[0].data;
            resp_q.delete(0);
        end else begin
            mem_rvalid     = resp_q.size() == 0 && chance(1);  // stray strobe with nothing owed
            mem_err        = chance(4);
            mem_rdata.full = {next_rand(), next_rand()};
        end
    endtask

    task automatic check_cycle(input int max_gap);
        logic             full;
        logic             s_win;
        logic             f_win;
        logic             hit;
        logic [2:0]       exp_gnt;
        logic [WORD_W-1:0] w;
        logic [BUS_W-1:0] word;
        bus_req_t         exp_req;
        word_rsp_t        exp_f;
        word_rsp_t        exp_s;
        vector_rsp_t      exp_v;
        exp_t             e;
        mem_rsp_t         r;

        full    = exp_q.size() == TXN_DEPTH;
        s_win   = scalar_req.valid && !vector_req.valid
                  && !(pending_store || (pending_load && scalar_req.we));
        f_win   = fetch_req.valid && !vector_req.valid && !s_win;
        exp_gnt = full ? 3'b000 : {f_win, s_win, vector_req.valid};
        full_cycles += int'(full);
        check_grants({fetch_gnt, scalar_gnt, vector_gnt}, exp_gnt);

        exp_req     = '0;
        exp_req.req = |exp_gnt;
        if (exp_gnt[0]) begin
            exp_req.we         = vector_req.we;
            exp_req.addr       = vector_req.addr;
            exp_req.be         = vector_req.be;
            exp_req.wdata.full = vector_req.wdata;
        end else if (exp_gnt[1]) begin
            exp_req.we         = scalar_req.we;
            exp_req.addr       = scalar_req.addr;
            exp_req.be         = scalar_req.addr[2] ? {scalar_req.be, 4'h0} : {4'h0, scalar_req.be};
            exp_req.wdata.full = {scalar_req.wdata, scalar_req.wdata};
        end else if (exp_gnt[2]) begin
            exp_req.addr = fetch_req.addr;
            exp_req.be   = '1;
        end
        check_bus_req(mem_req, exp_req);

        // the oldest outstanding transaction owns this response
        e   = '0;
        hit = mem_rvalid && exp_q.size() > 0;
        if (hit) begin
            e = exp_q[0];
            exp_q.delete(0);
        end
        w           = e.lane ? e.data[BUS_W-1:WORD_W] : e.data[WORD_W-1:0];
        exp_f.valid = hit && e.src == SRC_FETCH;
        exp_f.err   = exp_f.valid && e.err;
        exp_f.data  = w;
        exp_s.valid = hit && e.src == SRC_SCALAR;
        exp_s.err   = exp_s.valid && e.err;
        exp_s.data  = w;
        exp_v.valid = hit && e.src == SRC_VECTOR;
        exp_v.err   = exp_v.valid && e.err;
        exp_v.data  = e.data;
        check_word_rsp("fetch", fetch_rsp, exp_f, exp_f.valid && !e.we);
        check_word_rsp("scalar", scalar_rsp, exp_s, exp_s.valid && !e.we);
        check_vector_rsp(vector_rsp, exp_v, exp_v.valid && !e.we);

        if (|exp_gnt) begin
            grants++;
            e.src  = exp_gnt[0] ? SRC_VECTOR : (exp_gnt[1] ? SRC_SCALAR : SRC_FETCH);
            e.we   = exp_req.we;
            e.err  = exp_req.addr[ADDR_W-1:28] == 4'hf;
            e.lane = exp_req.addr[2];
            e.data = mem_read(exp_req.addr);
            exp_q.push_back(e);
        end
        // the memory serves whatever the DUT put on the bus
        if (mem_req.req) begin
            r.err    = mem_req.addr[ADDR_W-1:28] == 4'hf;
            r.data   = mem_read(mem_req.addr);
            last_due = ((last_due > cycle) ? last_due : cycle) + 1 + int'(next_rand() % max_gap);
            r.due    = last_due;
            resp_q.push_back(r);
            word = r.data;
            for (int b = 0; b < BE_W; b++) begin
                if (mem_req.be[b]) begin
                    word[b*8 +: 8] = mem_req.wdata.full[b*8 +: 8];
                end
            end
            if (mem_req.we && !r.err) begin
                mem[mem_req.addr[ADDR_W-1:3]] = word;
            end
        end
        gnt_seen = {fetch_gnt, scalar_gnt, vector_gnt};
    endtask

    task automatic run_test(input string name, input int min_cycles, input int n_txn,
                            input int req_rate, input int pend_rate, input int max_gap);
        int cycles;
        cycles      = 0;
        grants      = 0;
        full_cycles = 0;
        test_errors = 0;
        while (cycles < min_cycles || grants < n_txn || exp_q.size() > 0
               || fetch_req.valid || scalar_req.valid || vector_req.valid) begin
            @(posedge clk_i);
            cycle++;
            #1;
            drive_inputs(req_rate, pend_rate, grants < n_txn);
            @(negedge clk_i);
            check_cycle(max_gap);
            cycles++;
        end
        $display("test %s: cycles %0d grants %0d full %0d errors %0d",
                 name, cycles, grants, full_cycles, test_errors);
        total_grants += grants;
        errors       += test_errors;
    endtask

    //////////////////////////////
    // clock, watchdog and sequence

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #((TOTAL_TXN * (MAX_LAT + 1) + 500) * CLK_PERIOD);
        $display("timeout: the fabric stopped granting or answering");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst_ni        = 1'b0;
        fetch_req     = '0;
        scalar_req    = '0;
        vector_req    = '0;
        pending_load  = 1'b0;
        pending_store = 1'b0;
        mem_rvalid    = 1'b0;
        mem_err       = 1'b0;
        mem_rdata     = '0;
        gnt_seen      = '0;
        cycle         = 0;
        last_due      = 0;
        total_grants  = 0;
        errors        = 0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        run_test("idle_after_reset", 32, 0, 0, 2, 1);
        run_test("mixed_traffic", 0, 250, 4, 2, 2);
        run_test("scalar_hold", 0, 150, 5, 5, 2);
        run_test("tracker_full", 0, 200, 8, 1, MAX_LAT);
        if (full_cycles == 0) begin
            $display("test tracker_full never filled the tracker");
            errors++;
        end
        $display("summary: 4 tests, %0d transactions, %0d errors", total_grants, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vproc_mem_fabric.f
src/fabric_cfg_pkg.sv
src/fabric_types_pkg.sv
src/mem_req_arbiter.sv
src/mem_txn_tracker.sv
src/mem_resp_router.sv
src/vproc_mem_fabric.sv
dv/mem_fabric_chk.sv
dv/tb_vproc_mem_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_vproc_mem_fabric
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$top" -f vproc_mem_fabric.f -o "V$top"
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

# keep running past assertion errors so the testbench reports them
./obj_dir/"V$top" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '*** PASSED ***' "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
